//--- vlog.f
hw/iso_mode_pkg.sv
hw/iso_dsp_pkg.sv
hw/hf_timebase.sv
hw/reader_field_detect.sv
hw/tag_mod_detect.sv
hw/arm_ssp_link.sv
hw/hi_iso14443a.sv
sim/hi_iso14443a_checker.sv
sim/tb_hi_iso14443a.sv

//--- Bender.yml
package:
  name: hi_iso14443a

sources:
  - hw/iso_mode_pkg.sv
  - hw/iso_dsp_pkg.sv
  - hw/hf_timebase.sv
  - hw/reader_field_detect.sv
  - hw/tag_mod_detect.sv
  - hw/arm_ssp_link.sv
  - hw/hi_iso14443a.sv
  - target: simulation
    files:
      - sim/hi_iso14443a_checker.sv
      - sim/tb_hi_iso14443a.sv

//--- sim/tb_hi_iso14443a.sv
//----------------------------
// testbench of the HF ISO14443-A front end, runs every mode through
// reset, SSP rates, both detectors, sniffing and the carrier gate
//----------------------------

module tb_hi_iso14443a
	import iso_mode_pkg::*;
	import iso_dsp_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// rules known to the reference function
	localparam int R_HYST = 0;
	localparam int R_LOSS = 1;
	localparam int R_SLOPE = 2;
	localparam int R_GATE = 3;

	logic adc_clk;
	logic fdt_reset;
	logic [ADC_W-1:0] adc_d;
	iso_mode_t mod_type;
	logic ssp_dout;
	logic ck_1356megb;
	logic ssp_clk;
	logic ssp_frame;
	logic ssp_din;
	logic pwr_hi;
	int errors = 0;
	int checks = 0;
	logic [7:0] lfsr_state = 8'd78;

	hi_iso14443a UUT (.*);

	initial
	begin
		adc_clk = 1'b0;
		forever #4 adc_clk = ~adc_clk;
	end

	// x^8 + x^6 + x^5 + x^4, one step per bit taken
	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
		lfsr_state = {lfsr_state[6:0], fb};
		return fb;
	endfunction

	// expected host bit for the hysteresis, field loss, slope and gate rules
	function automatic logic expect_bit(input int rule, input logic st, input int x,
		input int y, input int z);
		case (rule)
			R_HYST: return (x >= 16) ? 1'b1 : ((x < 8) ? 1'b0 : st);
			// y is the length of the run below 192
			R_LOSS: return (y >= 4096) ? 1'b1 : expect_bit(R_HYST, st, x, 0, 0);
			// x is the steepest fall, y the steepest rise
			R_SLOPE: return (x > 5) && (y > 5);
			// x is the mode, y the carrier, z the registered host bit
			R_GATE:
			begin
				if (x == int'(READER_MOD))
					return y[0] & ~z[0];
				else if (x == int'(READER_LISTEN))
					return y[0];
				return 1'b0;
			end
			default: return 1'bx;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	function automatic logic pick(input int sel);
		return (sel == 0) ? ssp_clk : ssp_frame;
	endfunction

	// count cycles up to the next edge of ssp_clk (0) or ssp_frame (1)
	task automatic wait_edge(input int sel, input logic to_one, input int limit,
		output int n);
		logic prev;
		logic cur;
		prev = pick(sel);
		n = 0;
		while (n < limit)
		begin
			@(negedge adc_clk);
			n++;
			cur = pick(sel);
			if ((cur === to_one) && (prev !== to_one))
				return;
			prev = cur;
		end
		errors++;
		$display("timeout: no edge on %s within %0d cycles", sel ? "ssp_frame" : "ssp_clk",
			limit);
		n = -1;
	endtask

	task automatic hold_adc(input int v, input int cycles);
		@(negedge adc_clk);
		adc_d = v;
		repeat (cycles - 1) @(negedge adc_clk);
	endtask

	// a short reset around each mode change keeps frames from merging
	task automatic set_mode(input iso_mode_t m);
		@(negedge adc_clk);
		fdt_reset = 1'b1;
		mod_type = m;
		ssp_dout = 1'b0;
		repeat (2) @(negedge adc_clk);
		fdt_reset = 1'b0;
	endtask

	task automatic check_rates(input string name, input int cp, input int fp, input int fw);
		int n;
		wait_edge(0, 1'b1, 100, n);
		wait_edge(0, 1'b1, 100, n);
		compare({name, " clk period"}, cp, n);
		wait_edge(1, 1'b1, 300, n);
		wait_edge(1, 1'b1, 300, n);
		compare({name, " frame period"}, fp, n);
		wait_edge(1, 1'b0, 300, n);
		compare({name, " frame width"}, fw, n);
	endtask

	// data is taken at each ssp_clk fall, once it has settled for the host
	task automatic sniff_byte(output logic [7:0] b);
		int n;
		b = '0;
		wait_edge(1, 1'b1, 200, n);
		for (int i = 0; i < 8; i++)
		begin
			wait_edge(0, 1'b0, 40, n);
			b = {b[6:0], ssp_din};
		end
	endtask

	initial
	begin
		static int lvl[5] = '{200, 12, 5, 12, 40};
		static int sq[8] = '{100, 100, 100, 100, 160, 160, 160, 160};
		static iso_mode_t gm[3] = '{READER_MOD, READER_LISTEN, SNIFFER};
		logic st;
		logic prev_dout;
		logic [7:0] b;
		int n;
		int f;
		int fmax;
		int rmax;
		fdt_reset = 1'b1;
		adc_d = 200;
		mod_type = SNIFFER;
		ssp_dout = 1'b0;
		ck_1356megb = 1'b0;
		repeat (16) @(negedge adc_clk);
		compare("reset ssp_clk", 0, ssp_clk);
		compare("reset ssp_frame", 0, ssp_frame);
		compare("reset ssp_din", 0, ssp_din);
		fdt_reset = 1'b0;

		// ------------------------------
		check_rates("sniffer", 8, 64, 8);
		set_mode(READER_LISTEN);
		check_rates("reader listen", 16, 128, 16);

		// hysteresis, then field loss from a low level
		set_mode(TAGSIM_LISTEN);
		st = 1'b0;
		foreach (lvl[i])
		begin
			hold_adc(lvl[i], 48);
			st = expect_bit(R_HYST, st, lvl[i], 0, 0);
			compare("hysteresis", st, ssp_din);
		end
		hold_adc(5, 48);
		compare("hysteresis low", expect_bit(R_HYST, 1'b1, 5, 0, 0), ssp_din);
		hold_adc(10, 1);
		n = 0;
		while ((ssp_din !== 1'b1) && (n < 4200))
		begin
			@(negedge adc_clk);
			n++;
		end
		if (ssp_din !== 1'b1)
			$display("timeout: field loss did not raise ssp_din within 4200 cycles");
		compare("field loss", expect_bit(R_LOSS, 1'b0, 10, 4096, 0), ssp_din);

		// ------------------------------
		// steepest slopes of the square wave under the filter weights
		fmax = 0;
		rmax = 0;
		for (int i = 0; i < 8; i++)
		begin
			f = 2 * sq[(i + 4) % 8] + sq[(i + 5) % 8] - sq[(i + 7) % 8] - 2 * sq[i];
			fmax = (f > fmax) ? f : fmax;
			rmax = (-f > rmax) ? -f : rmax;
		end
		set_mode(READER_LISTEN);
		for (int k = 0; k < 16; k++)
			hold_adc(sq[(k % 2) * 4], 4);
		compare("tag modulation", expect_bit(R_SLOPE, 1'b0, fmax, rmax, 0), ssp_din);
		hold_adc(130, 64);
		compare("tag silent", expect_bit(R_SLOPE, 1'b0, 0, 0, 0), ssp_din);

		// sniffing, reader nibble first
		set_mode(SNIFFER);
		hold_adc(200, 130);
		sniff_byte(b);
		st = expect_bit(R_HYST, 1'b0, 200, 0, 0);
		compare("sniff idle", {{4{st}}, 4'b0000}, b);
		hold_adc(0, 300);
		sniff_byte(b);
		st = expect_bit(R_HYST, 1'b1, 0, 0, 0);
		compare("sniff deep", {{4{st}}, 4'b0000}, b);

		// ------------------------------
		foreach (gm[j])
		begin
			set_mode(gm[j]);
			for (int i = 0; i < 64; i++)
			begin
				@(negedge adc_clk);
				// the coil still holds the host bit taken at the last rising edge
				prev_dout = ssp_dout;
				ck_1356megb = next_rand_bit();
				ssp_dout = (gm[j] == READER_MOD) ? next_rand_bit() : 1'b0;
				#1;
				compare("carrier gate", expect_bit(R_GATE, 1'b0, int'(gm[j]),
					ck_1356megb, prev_dout), pwr_hi);
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- sim/hi_iso14443a_checker.sv
//----------------------------
// protocol checks on the front end's host pins, bound into every
// instance of the top level by the bind at the end of this file
//----------------------------

module hi_iso14443a_checker
	import iso_mode_pkg::*;
(
	input logic      adc_clk,
	input logic      fdt_reset,
	input iso_mode_t mod_type,
	input logic      ssp_clk,
	input logic      ssp_frame,
	input logic      ssp_din,
	input logic      pwr_hi
);

	timeunit 1ns;
	timeprecision 100ps;

	// the carrier stays off while we only listen as a tag or sniff
	carrier_off_a: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		((mod_type == SNIFFER) || (mod_type == TAGSIM_LISTEN)) |-> !pwr_hi)
		else $error("pwr_hi driven while the mode keeps the carrier off");

	// the host pins still carry their reset values on the first free cycle
	reset_idle_a: assert property (@(posedge adc_clk)
		$fell(fdt_reset) |-> (!ssp_din && !ssp_clk && !ssp_frame))
		else $error("SSP pins not idle in the cycle after reset");

	// a frame lasts one SSP clock at most, which is 16 ticks at the slow rate
	frame_len_a: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		$rose(ssp_frame) |-> ##[1:16] !ssp_frame)
		else $error("ssp_frame stayed high longer than 16 cycles");

endmodule

bind hi_iso14443a hi_iso14443a_checker u_checker (.*);

//--- hw/hi_iso14443a.sv
//----------------------------
// top level of the HF ISO14443-A front end, connects the reader
// detector, tag detector and slot timebase to the host link
//----------------------------

module hi_iso14443a
	import iso_mode_pkg::*;
	import iso_dsp_pkg::*;
(
	input  logic             adc_clk,
	input  logic             fdt_reset,
	input  logic [ADC_W-1:0] adc_d,
	input  iso_mode_t        mod_type,
	input  logic             ssp_dout,
	input  logic             ck_1356megb,
	output logic             ssp_clk,
	output logic             ssp_frame,
	output logic             ssp_din,
	output logic             pwr_hi
);

	reader_status_t rdr;
	slot_timing_t slot;
	logic curbit;

	// reader side, shaped level and activity
	reader_field_detect u_reader_field_detect (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.rdr       (rdr)
	);

	hf_timebase u_hf_timebase (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.mod_type  (mod_type),
		.rdr       (rdr),
		.slot      (slot)
	);

	// tag side, one decision per bit window
	tag_mod_detect u_tag_mod_detect (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.slot      (slot),
		.curbit    (curbit)
	);

	arm_ssp_link u_arm_ssp_link (
		.adc_clk     (adc_clk),
		.fdt_reset   (fdt_reset),
		.mod_type    (mod_type),
		.rdr         (rdr),
		.slot        (slot),
		.curbit      (curbit),
		.ssp_dout    (ssp_dout),
		.ck_1356megb (ck_1356megb),
		.ssp_clk     (ssp_clk),
		.ssp_frame   (ssp_frame),
		.ssp_din     (ssp_din),
		.pwr_hi      (pwr_hi)
	);

endmodule

//--- hw/arm_ssp_link.sv
//----------------------------
// traffic to and from the host over SSP, with sniff sampling, the
// outgoing byte, clock and frame generation and the carrier gate
// that follows the host's modulation bit
//----------------------------

module arm_ssp_link
	import iso_mode_pkg::*;
	import iso_dsp_pkg::*;
(
	input  logic           adc_clk,
	input  logic           fdt_reset,
	input  iso_mode_t      mod_type,
	input  reader_status_t rdr,
	input  slot_timing_t   slot,
	input  logic           curbit,
	input  logic           ssp_dout,
	input  logic           ck_1356megb,
	output logic           ssp_clk,
	output logic           ssp_frame,
	output logic           ssp_din,
	output logic           pwr_hi
);

	logic sniff;
	logic [3:0] reader_nib;
	logic [3:0] tag_nib;
	logic [7:0] to_arm;
	logic send_sel;
	logic coil_bit;
	// rate dependent positions inside the SSP clock and frame periods
	logic [SLOT_W-1:0] clk_mask;
	logic [SLOT_W-1:0] frame_mask;
	logic [SLOT_W-1:0] clk_ph;
	logic [SLOT_W-1:0] frame_ph;
	logic [SLOT_W-1:0] byte_ph;
	logic [SLOT_W-1:0] frame_on;
	logic [SLOT_W-1:0] frame_off;

	assign sniff = (mod_type == SNIFFER);
	assign clk_mask = sniff ? SLOT_W'(SNIFF_CLK_DIV - 1) : SLOT_W'(SLOW_CLK_DIV - 1);
	assign frame_mask = sniff ? SLOT_W'(SNIFF_FRAME_LEN - 1) : SLOT_W'(SLOW_FRAME_LEN - 1);
	assign clk_ph = slot.cnt & clk_mask;
	assign frame_ph = slot.cnt & frame_mask;
	assign byte_ph = slot.cnt & SLOT_W'(SNIFF_FRAME_LEN - 1);
	// the slow frame starts 7 ticks in and both frames last one SSP clock
	assign frame_on = sniff ? '0 : SLOT_W'(7);
	assign frame_off = frame_on + clk_mask + 1'b1;

	//----------------------------
	// sniff sampling and byte
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			reader_nib <= '0;
			tag_nib <= '0;
			to_arm <= '0;
		end
		else
		begin
			if (slot.bit_strobe)
			begin
				reader_nib <= {reader_nib[2:0], rdr.level};
				tag_nib <= {tag_nib[2:0], curbit};
			end
			// tag data is meaningless while the reader itself is sending
			if (byte_ph == SLOT_W'(SNIFF_FRAME_LEN - 1))
				to_arm <= {reader_nib, rdr.deep ? 4'b0000 : tag_nib};
			else if (sniff && (clk_ph == '0) && (byte_ph != '0))
				to_arm <= {to_arm[6:0], 1'b0};
		end
	end

	// listen modes report one detector bit per 16-tick slot
	always_comb
	begin
		case (mod_type)
			TAGSIM_LISTEN: send_sel = rdr.level;
			READER_LISTEN: send_sel = curbit;
			default:       send_sel = 1'b0;
		endcase
	end

	//----------------------------
	// SSP signals and coil
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			ssp_clk <= 1'b0;
			ssp_frame <= 1'b0;
			ssp_din <= 1'b0;
			coil_bit <= 1'b0;
		end
		else
		begin
			// first half of each SSP period high, frame marks the start of a byte
			ssp_clk <= (clk_ph < ((clk_mask >> 1) + 1'b1));
			ssp_frame <= (frame_ph >= frame_on) && (frame_ph < frame_off);
			if (sniff)
				ssp_din <= to_arm[7];
			else if (slot.bit_strobe)
				ssp_din <= send_sel;
			coil_bit <= ssp_dout;
		end
	end

	// a host 1 pauses the carrier in READER_MOD, listening keeps it on
	always_comb
	begin
		case (mod_type)
			READER_MOD:    pwr_hi = ck_1356megb & ~coil_bit;
			READER_LISTEN: pwr_hi = ck_1356megb;
			default:       pwr_hi = 1'b0;
		endcase
	end

endmodule

//--- hw/tag_mod_detect.sv
//----------------------------
// finds tag load modulation in the ADC samples with a Gaussian
// derivative filter, deciding once per bit at the window close
//----------------------------

module tag_mod_detect
	import iso_dsp_pkg::*;
(
	input  logic             adc_clk,
	input  logic             fdt_reset,
	input  logic [ADC_W-1:0] adc_d,
	input  slot_timing_t     slot,
	output logic             curbit
);

	// past samples, tap 4 is the oldest
	logic [ADC_W-1:0] tap_1;
	logic [ADC_W-1:0] tap_2;
	logic [ADC_W-1:0] tap_3;
	logic [ADC_W-1:0] tap_4;
	logic signed [FILT_W-1:0] filt;
	logic signed [FILT_W-1:0] fall_max;
	logic signed [FILT_W-1:0] rise_max;

	always_ff @(posedge adc_clk)
	begin
		tap_4 <= tap_3;
		tap_3 <= tap_2;
		tap_2 <= tap_1;
		tap_1 <= adc_d;
	end

	// positive output means a falling carrier, negative a rising one
	// the outer taps carry double weight, all terms fit 11 signed bits
	assign filt = FILT_W'({tap_4, 1'b0}) + FILT_W'(tap_3) - FILT_W'(tap_1)
		- FILT_W'({adc_d, 1'b0});

	//----------------------------
	// windowed edge detector
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			curbit <= 1'b0;
			fall_max <= '0;
			rise_max <= '0;
		end
		else if (slot.win_close)
		begin
			// a modulated bit shows a steep edge in both directions
			curbit <= (fall_max > EDGE_MIN) && (rise_max > EDGE_MIN);
			fall_max <= '0;
			rise_max <= '0;
		end
		else if (filt > 0)
		begin
			if (filt > fall_max)
				fall_max <= filt;
		end
		else if (-filt > rise_max)
			rise_max <= -filt;
	end

endmodule

//--- hw/reader_field_detect.sv
//----------------------------
// shapes the reader's 100% ASK signal from raw ADC samples and
// tells the rest of the design when a reader is actively sending
//----------------------------

module reader_field_detect
	import iso_dsp_pkg::*;
(
	input  logic             adc_clk,
	input  logic             fdt_reset,
	input  logic [ADC_W-1:0] adc_d,
	output reader_status_t   rdr
);

	logic level;
	logic level_q;
	logic deep;
	logic [$clog2(FIELD_LOSS_TICKS)-1:0] low_cnt;
	logic [$clog2(DEEP_ON_TICKS)-1:0] zero_cnt;
	logic [$clog2(DEEP_OFF_TICKS)-1:0] live_cnt;

	// hysteresis keeps slow carrier ramps from toggling the shaped level
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			level <= 1'b0;
			low_cnt <= '0;
		end
		else
		begin
			if (adc_d >= HYST_HI)
				level <= 1'b1;
			else if (adc_d < HYST_LO)
				level <= 0;
			// a weak field for too long means no reader, report it as unmodulated
			if (adc_d >= FIELD_MIN)
				low_cnt <= '0;
			else if (low_cnt == FIELD_LOSS_TICKS - 1)
			begin
				low_cnt <= '0;
				level <= 1'b1;
			end
			else
				low_cnt <= low_cnt + 1'b1;
		end
	end

	//----------------------------
	// reader activity
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			deep <= 1'b0;
			zero_cnt <= '0;
			live_cnt <= '0;
		end
		else if (adc_d == '0)
		begin
			// the zero run counter parks at its top while the carrier stays off
			if (zero_cnt == DEEP_ON_TICKS - 1)
			begin
				deep <= 1'b1;
				live_cnt <= '0;
			end
			else
				zero_cnt <= zero_cnt + 1'b1;
		end
		else
		begin
			zero_cnt <= '0;
			// long steady carrier, the reader now waits for a tag answer
			if (live_cnt == DEEP_OFF_TICKS - 1)
				deep <= 1'b0;
			else
				live_cnt <= live_cnt + 1'b1;
		end
	end

	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			level_q <= 1'b0;
		else
			level_q <= level;
	end

	assign rdr = '{level: level, deep: deep, fall: level_q & ~level, rise: ~level_q & level};

endmodule

//--- hw/hf_timebase.sv
//----------------------------
// slot timebase of the front end, a free running 128-tick counter
// that follows the reader's bit grid while sniffing or listening as
// a tag, and places the tag modulation window in each bit
//----------------------------

module hf_timebase
	import iso_mode_pkg::*;
	import iso_dsp_pkg::*;
(
	input  logic           adc_clk,
	input  logic           fdt_reset,
	input  iso_mode_t      mod_type,
	input  reader_status_t rdr,
	output slot_timing_t   slot
);

	logic [SLOT_W-1:0] cnt;
	// position inside the current 16-tick bit
	logic [3:0] phase;
	// bit phase of the latest reader fall, 8 means nothing pending
	logic [3:0] fall_phase;
	// bit phase at which the modulation detector decides and restarts
	logic [3:0] win_phase;
	logic resync;

	assign phase = cnt[3:0];

	// only a reader that is actually sending can pull our timing
	assign resync = (phase == 4'(RESYNC_PHASE)) && rdr.deep &&
		((mod_type == SNIFFER) || (mod_type == TAGSIM_LISTEN));

	//----------------------------
	// slot counter with re-sync
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			cnt <= '0;
			fall_phase <= 4'd8;
		end
		else
		begin
			if (rdr.fall)
				fall_phase <= phase;
			if (resync)
			begin
				// reader edge came just after our sample point, so jump ahead
				if (fall_phase == 4'd1)
					cnt <= cnt + SLOT_W'(2);
				// reader edge came just before it, so lose one tick
				else if (fall_phase == 4'd0)
					cnt <= cnt;
				else
					cnt <= cnt + 1'b1;
				// one correction per detected edge
				fall_phase <= 4'd8;
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	//----------------------------
	// modulation window placement
	//----------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			win_phase <= 4'(LISTEN_RESET_PHASE);
		else if (mod_type == READER_LISTEN)
			// our own pause ends at phase 1, the tag answers 4 ticks on, ADC adds 3
			win_phase <= 4'(LISTEN_RESET_PHASE);
		else if ((mod_type == SNIFFER) && rdr.rise && rdr.deep)
			// the seen rise is late by RF, ADC and shaping delay, the answer by 7
			win_phase <= phase - 4'(SNIFF_PHASE_OFFSET);
	end

	assign slot = '{cnt: cnt, bit_strobe: (phase == 4'd0), win_close: (phase == win_phase)};

endmodule

//--- hw/iso_dsp_pkg.sv
//----------------------------
// sample widths, detector thresholds and slot constants of the
// ADC signal path, plus the status structs passed between blocks
//----------------------------

package iso_dsp_pkg;

	// raw ADC sample and signed derivative filter output
	localparam int ADC_W = 8;
	localparam int FILT_W = 11;

	// Schmitt trigger on the reader signal, roughly 1.14 V and 1.04 V
	localparam int HYST_HI = 16;
	localparam int HYST_LO = 8;

	// field considered lost after this many ticks below FIELD_MIN
	localparam int FIELD_MIN = 192;
	localparam int FIELD_LOSS_TICKS = 4096;

	// carrier off for 8 ticks marks an active reader, on for 256 ends it
	localparam int DEEP_ON_TICKS = 8;
	localparam int DEEP_OFF_TICKS = 256;

	// smallest slope that counts as a tag modulation edge
	localparam int EDGE_MIN = 5;

	// 128 ticks per host byte
	localparam int SLOT_W = 7;

	// phase of the modulation window close inside a 16-tick bit
	localparam int LISTEN_RESET_PHASE = 8;
	localparam int SNIFF_PHASE_OFFSET = 4;

	// bit phase at which the slot counter may be pulled toward the reader
	localparam int RESYNC_PHASE = 13;

	typedef struct packed
	{
		logic level;
		logic deep;
		logic fall;
		logic rise;
	} reader_status_t;

	typedef struct packed
	{
		logic [SLOT_W-1:0] cnt;
		logic bit_strobe;
		logic win_close;
	} slot_timing_t;

endpackage

//--- hw/iso_mode_pkg.sv
//----------------------------
// operating modes of the HF ISO14443-A front end and the SSP rates
// that go with them, shared by the slot timebase and the host link
//----------------------------

package iso_mode_pkg;

	// mode codes as written by the host into the mode register
	// code 2 belonged to tag emulation with modulation and is not decoded
	typedef enum logic [2:0]
	{
		SNIFFER       = 3'd0,
		TAGSIM_LISTEN = 3'd1,
		READER_LISTEN = 3'd3,
		READER_MOD    = 3'd4
	} iso_mode_t;

	// sniffing sends reader and tag nibbles, so the link runs twice as fast
	localparam int SNIFF_CLK_DIV = 8;
	localparam int SLOW_CLK_DIV = 16;

	// one frame carries a full byte in either rate
	localparam int SNIFF_FRAME_LEN = 64;
	localparam int SLOW_FRAME_LEN = 128;

endpackage
